// ==== kcpu_exec.f ====
common/kcpu_pkg.sv
common/kcpu_div_if.sv
alu/kcpu_alu.sv
alu/kcpu_div.sv
src/kcpu_exec.sv
bench/kcpu_exec_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= kcpu_exec_tb
FILELIST  ?= kcpu_exec.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/kcpu_exec_tb.sv ====
/* Execution unit testbench */
`timescale 1ns/100ps
`default_nettype none

module kcpu_exec_tb;

logic        clk;
logic        rst;
logic        start;
logic [7:0]  op;
logic [15:0] opnd0;
logic [15:0] opnd1;
logic        busy;
logic        done;
logic [15:0] rslt;
logic [15:0] rslt_hi;
logic [7:0]  cc;

logic        started;   // Set once the first start is driven
logic [7:0]  model_cc;  // CC expected after the last op
logic [7:0]  alu_ops [16] = '{kcpu_pkg::LDA,  kcpu_pkg::ADDA, kcpu_pkg::ADCA, kcpu_pkg::SUBA,
                              kcpu_pkg::ANDA, kcpu_pkg::EORA, kcpu_pkg::ORA,  kcpu_pkg::ADDD,
                              kcpu_pkg::SUBD, kcpu_pkg::CMPD, kcpu_pkg::NEGA, kcpu_pkg::INCA,
                              kcpu_pkg::DECA, kcpu_pkg::ASLA, kcpu_pkg::LSRA, kcpu_pkg::RORA};

kcpu_exec i_dut (
    .clk     ( clk     ),
    .rst     ( rst     ),
    .start   ( start   ),
    .op      ( op      ),
    .opnd0   ( opnd0   ),
    .opnd1   ( opnd1   ),
    .busy    ( busy    ),
    .done    ( done    ),
    .rslt    ( rslt    ),
    .rslt_hi ( rslt_hi ),
    .cc      ( cc      )
);

always #10 clk = ~clk;

task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
endtask

task automatic compare_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    assert (got === exp) else
        abort_run($sformatf("[FAIL] %s: got 0x%04h, expected 0x%04h", name, got, exp));
endtask

function automatic logic [15:0] random_word();
    logic [31:0] w;
    w = $urandom;
    return w[15:0];
endfunction

// 6809 style flag rules applied to one operation
function automatic void expected_result(
    input  logic [7:0]  code,
    input  logic [15:0] a,
    input  logic [15:0] b,
    input  logic [7:0]  cin,
    output logic [15:0] r,
    output logic [15:0] rh,
    output logic [7:0]  c
);
    logic [8:0]  s9;
    logic [16:0] s17;
    logic [31:0] p;
    logic [4:0]  nib;    // Low nibble sum, carry gives H
    logic [7:0]  r8;
    logic        cy;
    int          fmode;  // 1 byte Z/N, 2 word Z/N, 3 Z on product, 4 Z on quotient
    int          k;
    r     = a;
    rh    = 16'h0000;
    c     = cin;
    r8    = 8'h00;
    fmode = 1;
    cy    = (code == kcpu_pkg::ADCA) ? cin[kcpu_pkg::CC_C] : 1'b0;
    case (code)
        kcpu_pkg::LDA: begin
            r8                = b[7:0];
            c[kcpu_pkg::CC_V] = 1'b0;
        end
        kcpu_pkg::ADDA, kcpu_pkg::ADCA: begin
            s9                = {1'b0, a[7:0]} + {1'b0, b[7:0]} + {8'h00, cy};
            nib               = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'h0, cy};
            r8                = s9[7:0];
            c[kcpu_pkg::CC_C] = s9[8];
            c[kcpu_pkg::CC_V] = (a[7] == b[7]) && (r8[7] != a[7]);
            c[kcpu_pkg::CC_H] = nib[4];
        end
        kcpu_pkg::SUBA: begin
            r8                = a[7:0] - b[7:0];
            c[kcpu_pkg::CC_C] = a[7:0] < b[7:0];  // Borrow
            c[kcpu_pkg::CC_V] = (a[7] != b[7]) && (r8[7] != a[7]);
        end
        kcpu_pkg::ANDA, kcpu_pkg::EORA, kcpu_pkg::ORA: begin
            if (code == kcpu_pkg::ANDA) begin
                r8 = a[7:0] & b[7:0];
            end else if (code == kcpu_pkg::EORA) begin
                r8 = a[7:0] ^ b[7:0];
            end else begin
                r8 = a[7:0] | b[7:0];
            end
            c[kcpu_pkg::CC_V] = 1'b0;
        end
        kcpu_pkg::ADDD: begin
            s17               = {1'b0, a} + {1'b0, b};
            r                 = s17[15:0];
            c[kcpu_pkg::CC_C] = s17[16];
            c[kcpu_pkg::CC_V] = (a[15] == b[15]) && (r[15] != a[15]);
            fmode             = 2;
        end
        kcpu_pkg::SUBD, kcpu_pkg::CMPD: begin
            r                 = a - b;
            c[kcpu_pkg::CC_C] = a < b;
            c[kcpu_pkg::CC_V] = (a[15] != b[15]) && (r[15] != a[15]);
            fmode             = 2;
        end
        kcpu_pkg::NEGA: begin
            r8                = ~a[7:0] + 8'h01;
            c[kcpu_pkg::CC_C] = r8 != 8'h00;  // Borrow out of 0 - A
            c[kcpu_pkg::CC_V] = r8 == 8'h80;
        end
        kcpu_pkg::INCA: begin
            r8                = a[7:0] + 8'h01;
            c[kcpu_pkg::CC_V] = a[7:0] == 8'h7F;
        end
        kcpu_pkg::DECA: begin
            r8                = a[7:0] - 8'h01;
            c[kcpu_pkg::CC_V] = a[7:0] == 8'h80;
        end
        kcpu_pkg::ASLA: begin
            r8                = {a[6:0], 1'b0};
            c[kcpu_pkg::CC_C] = a[7];
            c[kcpu_pkg::CC_V] = r8[7] ^ a[7];  // N xor C
        end
        kcpu_pkg::LSRA, kcpu_pkg::RORA: begin
            r8                = {(code == kcpu_pkg::RORA) & cin[kcpu_pkg::CC_C], a[7:1]};
            c[kcpu_pkg::CC_C] = a[0];
        end
        kcpu_pkg::ANDCC: begin
            c     = cin & b[7:0];
            fmode = 0;
        end
        kcpu_pkg::ORCC: begin
            c     = cin | b[7:0];
            fmode = 0;
        end
        kcpu_pkg::MUL: begin
            r                 = {8'h00, a[15:8]} * {8'h00, a[7:0]};
            c[kcpu_pkg::CC_C] = r[7];
            fmode             = 3;
        end
        kcpu_pkg::LMUL: begin
            p                 = {16'h0000, a} * {16'h0000, b};
            r                 = p[15:0];
            rh                = p[31:16];
            c[kcpu_pkg::CC_C] = p[31];
            fmode             = 3;
        end
        kcpu_pkg::DIVXB: begin
            if (b[7:0] == 8'h00) begin
                r  = 16'hFFFF;
                rh = {8'h00, a[7:0]};
            end else begin
                r  = a / {8'h00, b[7:0]};
                rh = a % {8'h00, b[7:0]};
            end
            c[kcpu_pkg::CC_V] = b[7:0] == 8'h00;
            fmode             = 4;
        end
        kcpu_pkg::ASLD, kcpu_pkg::LSRD: begin
            for (k = 0; k < int'(b[7:0]); k++) begin
                if (code == kcpu_pkg::ASLD) begin
                    c[kcpu_pkg::CC_C] = r[15];
                    r                 = {r[14:0], 1'b0};
                    c[kcpu_pkg::CC_V] = r[15] ^ c[kcpu_pkg::CC_C];
                end else begin
                    c[kcpu_pkg::CC_C] = r[0];
                    r                 = {1'b0, r[15:1]};
                end
            end
            fmode = (b[7:0] != 8'h00) ? 2 : 0;  // Zero count leaves D and CC alone
        end
        default: fmode = 0;
    endcase
    case (fmode)
        1: begin
            r                 = {8'h00, r8};
            c[kcpu_pkg::CC_Z] = r8 == 8'h00;
            c[kcpu_pkg::CC_N] = r8[7];
        end
        2: begin
            c[kcpu_pkg::CC_Z] = r == 16'h0000;
            c[kcpu_pkg::CC_N] = r[15];
        end
        3: c[kcpu_pkg::CC_Z] = {rh, r} == 32'h0000_0000;
        4: c[kcpu_pkg::CC_Z] = r == 16'h0000;
        default: ;
    endcase
endfunction

// One operation, optionally with a second start pulsed while busy
task automatic issue_op(input logic [7:0] code, input logic [15:0] a,
                        input logic [15:0] b, input logic poke);
    logic [15:0] exp_r;
    logic [15:0] exp_rh;
    logic [7:0]  exp_cc;
    int          waited;
    expected_result(code, a, b, model_cc, exp_r, exp_rh, exp_cc);
    started = 1'b1;
    start   = 1'b1;
    op      = code;
    opnd0   = a;
    opnd1   = b;
    @(negedge clk);
    start = 1'b0;
    if (poke) begin
        @(negedge clk);
        assert (busy) else abort_run("DUT not busy when the second start was driven");
        start = 1'b1;
        op    = kcpu_pkg::LSRD;
        opnd0 = ~a;
        opnd1 = 16'h0003;
        @(negedge clk);
        start = 1'b0;
    end
    waited = 0;
    while (!done && waited < 40) begin
        @(negedge clk);
        waited++;
    end
    assert (done) else
        abort_run($sformatf("no done from the DUT within 40 cycles for op 0x%02h", code));
    compare_value("rslt", rslt, exp_r);
    compare_value("rslt_hi", rslt_hi, exp_rh);
    compare_value("cc", {8'h00, cc}, {8'h00, exp_cc});
    model_cc = exp_cc;
    if (poke) begin
        repeat (3) begin
            @(negedge clk);
            assert (!done && !busy) else abort_run("start while busy was not ignored");
        end
    end
endtask

task automatic mixed_ops(input int n);
    logic [31:0] pick;
    int          k;
    for (k = 0; k < n; k++) begin
        pick = $urandom;
        issue_op(alu_ops[pick[3:0]], random_word(), random_word(), 1'b0);
    end
endtask

a_reset_quiet: assert property (@(posedge clk) (!rst && !started) |->
    (!busy && !done && cc == 8'h00 && rslt == 16'h0000 && rslt_hi == 16'h0000))
    else abort_run("outputs not cleared after reset");

a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else abort_run("done held high for more than one cycle");

a_result_hold: assert property (@(posedge clk) disable iff (rst)
    !done |-> ($stable(rslt) && $stable(rslt_hi) && $stable(cc)))
    else abort_run("results changed without a done pulse");

initial begin
    int i;
    void'($urandom(73));
    clk      = 1'b0;
    rst      = 1'b1;
    start    = 1'b0;
    op       = kcpu_pkg::NOP;
    opnd0    = 16'h0000;
    opnd1    = 16'h0000;
    started  = 1'b0;
    model_cc = 8'h00;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    repeat (3) @(negedge clk);  // Idle window before the first start

    mixed_ops(100);  // Carry and CC chained from op to op

    issue_op(kcpu_pkg::ORCC, random_word(), 16'h00D0, 1'b0);  // Set E, F and I
    mixed_ops(20);
    for (i = 0; i < 10; i++) begin
        issue_op(kcpu_pkg::ANDCC, random_word(), random_word(), 1'b0);
        mixed_ops(1);
        issue_op(kcpu_pkg::ORCC, random_word(), random_word(), 1'b0);
        mixed_ops(1);
    end

    issue_op(kcpu_pkg::MUL, 16'hFF00, random_word(), 1'b0);  // Zero product
    issue_op(kcpu_pkg::LMUL, 16'hFFFF, 16'hFFFF, 1'b0);
    for (i = 0; i < 20; i++) begin
        issue_op(kcpu_pkg::MUL, random_word(), random_word(), 1'b0);
        issue_op(kcpu_pkg::LMUL, random_word(), random_word(), 1'b0);
    end

    issue_op(kcpu_pkg::DIVXB, random_word(), 16'h1200, 1'b0);  // Zero low byte
    issue_op(kcpu_pkg::DIVXB, 16'hBEEF, 16'h0000, 1'b0);
    for (i = 0; i < 20; i++) begin
        issue_op(kcpu_pkg::DIVXB, random_word(), random_word(), 1'b0);
    end

    for (i = 0; i <= 20; i++) begin
        issue_op(kcpu_pkg::ASLD, random_word(), (random_word() & 16'hFF00) | 16'(i), 1'b0);
        issue_op(kcpu_pkg::LSRD, random_word(), (random_word() & 16'hFF00) | 16'(i), 1'b0);
    end
    issue_op(kcpu_pkg::ASLD, random_word(), 16'h000C, 1'b1);

    $display("Test passed");
    $finish;
end

initial begin
    repeat (40 * 268) @(posedge clk);  // 268 operations
    abort_run("watchdog expired before all operations finished");
end

endmodule

`default_nettype wire

// ==== src/kcpu_exec.sv ====
/* Execution unit top */
`timescale 1ns/100ps
`default_nettype none

module kcpu_exec (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         start,
    input  wire [7:0]                   op,
    input  wire [kcpu_pkg::DATA_W-1:0]  opnd0,
    input  wire [kcpu_pkg::DATA_W-1:0]  opnd1,
    output logic                        busy,
    output logic                        done,
    output logic [kcpu_pkg::DATA_W-1:0] rslt,
    output logic [kcpu_pkg::DATA_W-1:0] rslt_hi,
    output logic [kcpu_pkg::CC_W-1:0]   cc
);

typedef enum logic [2:0] {IDLE, EXEC, SHIFT, DIVIDE, FINISH} state_e;

state_e                      state;
kcpu_pkg::kcpu_op_e          op_in;
kcpu_pkg::kcpu_op_e          op_r;
kcpu_pkg::kcpu_op_e          alu_op;
logic [kcpu_pkg::DATA_W-1:0] a_r;       // Working value, fed back on shifts
logic [kcpu_pkg::DATA_W-1:0] b_r;
logic [kcpu_pkg::CC_W-1:0]   cc_w;      // Working CC
logic [7:0]                  cnt;       // Shift steps left
logic                        div_start;
logic                        shift_op;
logic                        commit;
logic [kcpu_pkg::DATA_W-1:0] alu_rslt;
logic [kcpu_pkg::DATA_W-1:0] alu_rslt_hi;
logic [kcpu_pkg::CC_W-1:0]   alu_cc;

kcpu_div_if i_div_if (.clk(clk));

assign op_in               = kcpu_pkg::kcpu_op_e'(op);
assign shift_op            = op_r == kcpu_pkg::ASLD || op_r == kcpu_pkg::LSRD;
assign alu_op              = (shift_op && cnt == 8'd0) ? kcpu_pkg::NOP : op_r;  // Zero count
assign busy                = state != IDLE;
assign commit              = state == EXEC || state == FINISH
                             || (state == SHIFT && cnt == 8'd1);
assign i_div_if.start      = div_start;
assign i_div_if.dividend   = a_r;
assign i_div_if.divisor    = b_r[7:0];

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        state     <= IDLE;
        op_r      <= kcpu_pkg::NOP;
        cc_w      <= '0;
        cnt       <= 8'd0;
        div_start <= 1'b0;
        done      <= 1'b0;
        rslt      <= '0;
        rslt_hi   <= '0;
        cc        <= '0;
    end else begin
        done      <= 1'b0;
        div_start <= 1'b0;
        if (commit) begin
            rslt    <= alu_rslt;
            rslt_hi <= alu_rslt_hi;
            cc      <= alu_cc;
            done    <= 1'b1;
            state   <= IDLE;
        end
        case (state)
            IDLE: if (start) begin
                op_r <= op_in;
                cc_w <= cc;
                cnt  <= opnd1[7:0];
                if (op_in == kcpu_pkg::DIVXB) begin
                    state     <= DIVIDE;
                    div_start <= 1'b1;
                end else if ((op_in == kcpu_pkg::ASLD || op_in == kcpu_pkg::LSRD)
                             && opnd1[7:0] != 8'd0) begin
                    state <= SHIFT;
                end else begin
                    state <= EXEC;
                end
            end
            SHIFT: if (cnt != 8'd1) begin
                cc_w <= alu_cc;
                cnt  <= cnt - 8'd1;
            end
            DIVIDE: if (!i_div_if.busy && !div_start) begin  // Quotient settled
                state <= FINISH;
            end
            default: ;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (state == IDLE && start) begin
        a_r <= opnd0;
        b_r <= opnd1;
    end else if (state == SHIFT) begin
        a_r <= alu_rslt;
    end
end

kcpu_alu i_alu (
    .op       ( alu_op         ),
    .a        ( a_r            ),
    .b        ( b_r            ),
    .cc_in    ( cc_w           ),
    .div_quot ( i_div_if.quot  ),
    .div_rem  ( i_div_if.rem   ),
    .div_ovf  ( i_div_if.ovf   ),
    .rslt     ( alu_rslt       ),
    .rslt_hi  ( alu_rslt_hi    ),
    .cc_out   ( alu_cc         )
);

kcpu_div i_div (
    .clk ( clk      ),
    .rst ( rst      ),
    .div ( i_div_if )
);

a_done_idle: assert property (@(posedge clk) disable iff (rst) !(done && busy))
    else $error("done while busy");

endmodule

`default_nettype wire

// ==== alu/kcpu_div.sv ====
/* Serial restoring divider */
`timescale 1ns/100ps
`default_nettype none

module kcpu_div (
    input wire       clk,
    input wire       rst,
    kcpu_div_if.unit div
);

logic [$clog2(kcpu_pkg::DIV_STEPS+1)-1:0] cnt;  // Steps left
logic [kcpu_pkg::DATA_W-1:0]              q;    // Dividend in, quotient out
logic [7:0]                               dvs;
logic [7:0]                               pr;   // Partial remainder
logic [8:0]                               trial;
logic [8:0]                               diff;
logic                                     launch;

assign launch   = div.start && !div.busy;
assign trial    = {pr, q[kcpu_pkg::DATA_W-1]};  // Next dividend bit shifted in
assign diff     = trial - {1'b0, dvs};
assign div.quot = q;
assign div.rem  = pr;

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        div.busy <= 1'b0;
        div.ovf  <= 1'b0;
        cnt      <= '0;
    end else if (launch) begin
        div.busy <= 1'b1;
        div.ovf  <= div.divisor == 8'h00;
        cnt      <= $bits(cnt)'(kcpu_pkg::DIV_STEPS);
    end else if (div.busy) begin
        cnt <= cnt - 1'b1;
        if (cnt == 1) begin
            div.busy <= 1'b0;
        end
    end
end

// Zero divisor falls out as all ones with the low byte left in pr
always_ff @(posedge clk) begin
    if (launch) begin
        q   <= div.dividend;
        dvs <= div.divisor;
        pr  <= 8'h00;
    end else if (div.busy) begin
        if (trial >= {1'b0, dvs}) begin
            pr <= diff[7:0];
            q  <= {q[kcpu_pkg::DATA_W-2:0], 1'b1};
        end else begin
            pr <= trial[7:0];  // Restore
            q  <= {q[kcpu_pkg::DATA_W-2:0], 1'b0};
        end
    end
end

a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
    div.start |-> !div.busy)
    else $error("divider start while busy");

a_busy_len: assert property (@(posedge clk) disable iff (rst)
    $rose(div.busy) |-> div.busy [*kcpu_pkg::DIV_STEPS] ##1 !div.busy)
    else $error("divider busy length");

endmodule

`default_nettype wire

// ==== alu/kcpu_alu.sv ====
/* Single step ALU */
`timescale 1ns/100ps
`default_nettype none

module kcpu_alu (
    input  wire kcpu_pkg::kcpu_op_e     op,
    input  wire [kcpu_pkg::DATA_W-1:0]  a,
    input  wire [kcpu_pkg::DATA_W-1:0]  b,
    input  wire [kcpu_pkg::CC_W-1:0]    cc_in,
    input  wire [kcpu_pkg::DATA_W-1:0]  div_quot,
    input  wire [7:0]                   div_rem,
    input  wire                         div_ovf,
    output logic [kcpu_pkg::DATA_W-1:0] rslt,
    output logic [kcpu_pkg::DATA_W-1:0] rslt_hi,
    output logic [kcpu_pkg::CC_W-1:0]   cc_out
);

logic                        byte_op;  // Result and flags on the low byte
logic                        up_z;
logic                        up_n;
logic [7:0]                  r8;
logic [kcpu_pkg::DATA_W-1:0] r16;

always_comb begin
    byte_op = 1'b0;
    up_z    = 1'b0;
    up_n    = 1'b0;
    case (op)
        kcpu_pkg::LDA,  kcpu_pkg::ADDA, kcpu_pkg::ADCA, kcpu_pkg::SUBA,
        kcpu_pkg::ANDA, kcpu_pkg::EORA, kcpu_pkg::ORA,  kcpu_pkg::NEGA,
        kcpu_pkg::INCA, kcpu_pkg::DECA, kcpu_pkg::ASLA, kcpu_pkg::LSRA,
        kcpu_pkg::RORA: begin
            byte_op = 1'b1;
            up_z    = 1'b1;
            up_n    = 1'b1;
        end
        kcpu_pkg::ADDD, kcpu_pkg::SUBD, kcpu_pkg::CMPD,
        kcpu_pkg::ASLD, kcpu_pkg::LSRD: begin
            up_z = 1'b1;
            up_n = 1'b1;
        end
        kcpu_pkg::MUL, kcpu_pkg::LMUL, kcpu_pkg::DIVXB: begin
            up_z = 1'b1;  // N is left alone
        end
        default: ;
    endcase
end

always_comb begin
    cc_out  = cc_in;
    r8      = a[7:0];
    r16     = a;
    rslt_hi = '0;
    case (op)
        kcpu_pkg::LDA: begin
            r8                     = b[7:0];
            cc_out[kcpu_pkg::CC_V] = 1'b0;
        end
        kcpu_pkg::ADDA: begin
            {cc_out[kcpu_pkg::CC_C], r8} = {1'b0, a[7:0]} + {1'b0, b[7:0]};
            cc_out[kcpu_pkg::CC_V] = a[7] ^ b[7] ^ cc_out[kcpu_pkg::CC_C] ^ r8[7];
            cc_out[kcpu_pkg::CC_H] = a[4] ^ b[4] ^ r8[4];  // Carry into bit 4
        end
        kcpu_pkg::ADCA: begin
            {cc_out[kcpu_pkg::CC_C], r8} = {1'b0, a[7:0]} + {1'b0, b[7:0]}
                                         + {8'h00, cc_in[kcpu_pkg::CC_C]};
            cc_out[kcpu_pkg::CC_V] = a[7] ^ b[7] ^ cc_out[kcpu_pkg::CC_C] ^ r8[7];
            cc_out[kcpu_pkg::CC_H] = a[4] ^ b[4] ^ r8[4];
        end
        kcpu_pkg::SUBA: begin
            {cc_out[kcpu_pkg::CC_C], r8} = {1'b0, a[7:0]} - {1'b0, b[7:0]};  // C is borrow
            cc_out[kcpu_pkg::CC_V] = a[7] ^ b[7] ^ cc_out[kcpu_pkg::CC_C] ^ r8[7];
        end
        kcpu_pkg::ANDA: begin
            r8                     = a[7:0] & b[7:0];
            cc_out[kcpu_pkg::CC_V] = 1'b0;
        end
        kcpu_pkg::EORA: begin
            r8                     = a[7:0] ^ b[7:0];
            cc_out[kcpu_pkg::CC_V] = 1'b0;
        end
        kcpu_pkg::ORA: begin
            r8                     = a[7:0] | b[7:0];
            cc_out[kcpu_pkg::CC_V] = 1'b0;
        end
        kcpu_pkg::ADDD: begin
            {cc_out[kcpu_pkg::CC_C], r16} = {1'b0, a} + {1'b0, b};
            cc_out[kcpu_pkg::CC_V] = a[15] ^ b[15] ^ cc_out[kcpu_pkg::CC_C] ^ r16[15];
        end
        kcpu_pkg::SUBD, kcpu_pkg::CMPD: begin  // CPU drops the CMPD write-back
            {cc_out[kcpu_pkg::CC_C], r16} = {1'b0, a} - {1'b0, b};
            cc_out[kcpu_pkg::CC_V] = a[15] ^ b[15] ^ cc_out[kcpu_pkg::CC_C] ^ r16[15];
        end
        kcpu_pkg::NEGA: begin
            r8                     = 8'h00 - a[7:0];
            cc_out[kcpu_pkg::CC_C] = a[7:0] != 8'h00;
            cc_out[kcpu_pkg::CC_V] = a[7:0] == 8'h80;
        end
        kcpu_pkg::INCA: begin
            r8                     = a[7:0] + 8'h01;
            cc_out[kcpu_pkg::CC_V] = r8 == 8'h80;  // 7F wrapped
        end
        kcpu_pkg::DECA: begin
            r8                     = a[7:0] - 8'h01;
            cc_out[kcpu_pkg::CC_V] = r8 == 8'h7F;
        end
        kcpu_pkg::ASLA: begin
            {cc_out[kcpu_pkg::CC_C], r8} = {a[7:0], 1'b0};
            cc_out[kcpu_pkg::CC_V] = a[7] ^ a[6];
        end
        kcpu_pkg::LSRA: {r8, cc_out[kcpu_pkg::CC_C]} = {1'b0, a[7:0]};
        kcpu_pkg::RORA: {r8, cc_out[kcpu_pkg::CC_C]} = {cc_in[kcpu_pkg::CC_C], a[7:0]};
        kcpu_pkg::ANDCC: cc_out = cc_in & b[7:0];
        kcpu_pkg::ORCC:  cc_out = cc_in | b[7:0];
        kcpu_pkg::MUL: begin
            r16                    = a[15:8] * a[7:0];  // A times B
            cc_out[kcpu_pkg::CC_C] = r16[7];
        end
        kcpu_pkg::LMUL: begin
            {rslt_hi, r16}         = a * b;
            cc_out[kcpu_pkg::CC_C] = rslt_hi[15];
        end
        kcpu_pkg::DIVXB: begin
            r16                    = div_quot;
            rslt_hi                = {8'h00, div_rem};
            cc_out[kcpu_pkg::CC_V] = div_ovf;
        end
        kcpu_pkg::ASLD: begin  // One step of the count
            {cc_out[kcpu_pkg::CC_C], r16} = {a, 1'b0};
            cc_out[kcpu_pkg::CC_V] = a[15] ^ a[14];
        end
        kcpu_pkg::LSRD: {r16, cc_out[kcpu_pkg::CC_C]} = {1'b0, a};
        default: ;  // NOP passes a through
    endcase

    rslt = byte_op ? {8'h00, r8} : r16;

    if (up_z) begin
        if (byte_op) begin
            cc_out[kcpu_pkg::CC_Z] = r8 == 8'h00;
        end else if (op == kcpu_pkg::LMUL) begin
            cc_out[kcpu_pkg::CC_Z] = {rslt_hi, r16} == '0;  // Full product
        end else begin
            cc_out[kcpu_pkg::CC_Z] = r16 == '0;
        end
    end
    if (up_n) begin
        cc_out[kcpu_pkg::CC_N] = byte_op ? r8[7] : r16[kcpu_pkg::DATA_W-1];
    end
end

// Mask bits belong to the CC byte ops only
always_comb begin
    if (op != kcpu_pkg::ANDCC && op != kcpu_pkg::ORCC) begin
        assert final (cc_out[kcpu_pkg::CC_E] == cc_in[kcpu_pkg::CC_E] &&
                      cc_out[kcpu_pkg::CC_F] == cc_in[kcpu_pkg::CC_F] &&
                      cc_out[kcpu_pkg::CC_I] == cc_in[kcpu_pkg::CC_I])
        else $error("E/F/I changed outside ANDCC/ORCC");
    end
end

endmodule

`default_nettype wire

// ==== common/kcpu_div_if.sv ====
/* Divider handshake */
`timescale 1ns/100ps
`default_nettype none

interface kcpu_div_if (
    input wire clk
);

logic                        start;     // One-cycle launch pulse
logic [kcpu_pkg::DATA_W-1:0] dividend;
logic [7:0]                  divisor;
logic [kcpu_pkg::DATA_W-1:0] quot;      // Valid once busy falls
logic [7:0]                  rem;
logic                        busy;
logic                        ovf;       // Zero divisor seen at start

modport ctrl (
    input  clk,
    output start, dividend, divisor,
    input  quot, rem, busy, ovf
);

modport unit (
    input  clk,
    input  start, dividend, divisor,
    output quot, rem, busy, ovf
);

endinterface

`default_nettype wire

// ==== common/kcpu_pkg.sv ====
/* Execution unit definitions */
`default_nettype none

package kcpu_pkg;

localparam int DATA_W    = 16;  // Operand and result width
localparam int CC_W      = 8;   // Condition code width
localparam int DIV_STEPS = 16;  // One quotient bit per step

// CC byte layout, E F H I N Z V C from bit 7 down
localparam int CC_C = 0;
localparam int CC_V = 1;
localparam int CC_Z = 2;
localparam int CC_N = 3;
localparam int CC_I = 4;
localparam int CC_H = 5;
localparam int CC_F = 6;
localparam int CC_E = 7;

typedef enum logic [7:0] {
    // 8-bit accumulator ops
    LDA   = 8'h86,
    ADDA  = 8'h8B,
    ADCA  = 8'h89,
    SUBA  = 8'h80,
    ANDA  = 8'h84,
    EORA  = 8'h88,
    ORA   = 8'h8A,
    // 16-bit ops on D
    ADDD  = 8'hC3,
    SUBD  = 8'h83,
    CMPD  = 8'h93,
    // Inherent 8-bit ops
    NEGA  = 8'h40,
    INCA  = 8'h4C,
    DECA  = 8'h4A,
    ASLA  = 8'h48,
    LSRA  = 8'h44,
    RORA  = 8'h46,
    // CC byte
    ANDCC = 8'h1C,
    ORCC  = 8'h1A,
    // Multiply and divide
    MUL   = 8'h3D,
    LMUL  = 8'h3E,
    DIVXB = 8'h3F,
    // Multi-step shifts of D
    ASLD  = 8'hD8,
    LSRD  = 8'hD4,
    NOP   = 8'h12
} kcpu_op_e;

endpackage

`default_nettype wire
